/* hdl/DecodeTypes.sv */
// Shared widths, structs and register map of the decode subsystem.
// Bundle geometry is fixed at two instructions of two micro-ops each;
// the picker and resolver loops follow these constants.

package DecodeTypes;

    // Bundle geometry
    localparam int DecodeWidth     = 2;
    localparam int MicroOpMaxNum   = 2;
    localparam int AllMicroOpWidth = DecodeWidth * MicroOpMaxNum;

    // Widths with a meaning
    typedef logic [31:0]                        PcT;
    typedef logic [7:0]                         OpCodeT;
    typedef logic [$clog2(AllMicroOpWidth)-1:0] MopIndexT;
    typedef logic [$clog2(DecodeWidth)-1:0]     LaneIndexT;
    typedef logic [AllMicroOpWidth-1:0]         MopMaskT;
    typedef logic [3:0]                         WbAddrT;
    typedef logic [31:0]                        WbDataT;

    // One pre-formed micro-op
    typedef struct packed {
        logic                             valid;
        logic                             serialized;
        logic [$clog2(MicroOpMaxNum)-1:0] mid;
        OpCodeT                           opCode;
    } MicroOp;

    // One instruction lane as delivered by the front end
    typedef struct packed {
        logic                        valid;
        PcT                          pc;
        logic                        isJump;
        logic                        predTaken;
        PcT                          jumpTarget;
        MicroOp [MicroOpMaxNum-1:0]  microOps;
    } InsnSlot;

    typedef InsnSlot [DecodeWidth-1:0] DecodeBundle;

    // One rename lane
    typedef struct packed {
        logic   valid;
        PcT     pc;
        logic   predTaken;
        MicroOp op;
    } IssuedOp;

    typedef IssuedOp [DecodeWidth-1:0] IssueLanes;

    // Control bits written through the register port
    typedef struct packed {
        logic resolverEnable;
        logic serializeAll;
    } DecodeCtrl;

    localparam DecodeCtrl CtrlReset = '{resolverEnable: 1'b1, serializeAll: 1'b0};

    // Register map in word addresses
    localparam WbAddrT RegCtrlAddr       = WbAddrT'(0);
    localparam WbAddrT RegFlushCountAddr = WbAddrT'(1);

    // Bit positions inside the control word
    localparam int CtrlResolverBit  = 0;
    localparam int CtrlSerializeBit = 1;

    // Redirect counter sticks here
    localparam WbDataT FlushCountMax = '1;

endpackage

/* hdl/MicroOpPicker.sv */
// In-order selection of up to DecodeWidth micro-ops from a pending mask.
// A serialized micro-op only goes out as the first pick of a cycle and
// stops picking for the rest of that cycle. Purely combinational.

`timescale 1ns/1ps

module MicroOpPicker (
    input  DecodeTypes::MopMaskT                           req,
    input  DecodeTypes::MopMaskT                           serialize,
    output logic [DecodeTypes::DecodeWidth-1:0]            picked,
    output DecodeTypes::MopIndexT [DecodeTypes::DecodeWidth-1:0] pickedIndex,
    output DecodeTypes::MopMaskT                           next
);

    DecodeTypes::MopMaskT cur;
    logic                 stop;
    logic                 sent;
    logic                 found;

    always_comb begin
        cur  = req;
        stop = 1'b0;
        sent = 1'b0;

        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            picked[i]      = 1'b0;
            pickedIndex[i] = '0;
            found          = 1'b0;
            for (int mn = 0; mn < DecodeTypes::AllMicroOpWidth; mn++) begin
                if (cur[mn] && !found && !stop) begin
                    found = 1'b1;
                    if (serialize[mn]) begin
                        // Goes alone, so it waits if something was already sent
                        stop = 1'b1;
                        if (!sent) begin
                            picked[i]      = 1'b1;
                            pickedIndex[i] = DecodeTypes::MopIndexT'(mn);
                            cur[mn]        = 1'b0;
                            sent           = 1'b1;
                        end
                    end else begin
                        picked[i]      = 1'b1;
                        pickedIndex[i] = DecodeTypes::MopIndexT'(mn);
                        cur[mn]        = 1'b0;
                        sent           = 1'b1;
                    end
                end
            end
        end

        next = cur;
    end

endmodule

/* hdl/DecodedBranchResolver.sv */
// Early resolution of direct jumps predicted not-taken.
// Only the first such jump in program order redirects; every later lane
// of the bundle is reported invalid. Combinational, no state.

`timescale 1ns/1ps

module DecodedBranchResolver (
    input  DecodeTypes::DecodeBundle               bundle,
    input  logic                                   enable,
    output logic [DecodeTypes::DecodeWidth-1:0]    insnValidOut,
    output logic                                   flushReq,
    output DecodeTypes::PcT                        recoveredPc
);

    // Lanes that would redirect on their own
    logic [DecodeTypes::DecodeWidth-1:0] mispredicted;
    logic                                dropRest;

    always_comb begin
        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            mispredicted[i] = enable && bundle[i].valid &&
                              bundle[i].isJump && !bundle[i].predTaken;
        end
    end

    always_comb begin
        flushReq    = 1'b0;
        recoveredPc = '0;
        dropRest    = 1'b0;

        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            insnValidOut[i] = bundle[i].valid && !dropRest;

            // First surviving mispredicted jump wins
            if (mispredicted[i] && !dropRest) begin
                flushReq    = 1'b1;
                recoveredPc = bundle[i].jumpTarget;
                dropRest    = 1'b1;
            end
        end
    end

endmodule

/* hdl/DecodeStage.sv */
// Decode stage: registers one bundle and drains its micro-ops in order,
// at most DecodeWidth per cycle. The front end is held until the bundle
// completes. While outStall is high no state moves and outLanes hold,
// provided the control bits stay unchanged.

`timescale 1ns/1ps

module DecodeStage (
    input  logic                    clk,
    input  logic                    rstN,
    input  DecodeTypes::DecodeBundle inBundle,
    input  logic                    inValid,
    output logic                    inReady,
    input  logic                    outStall,
    input  DecodeTypes::DecodeCtrl  ctrl,
    output DecodeTypes::IssueLanes  outLanes,
    output logic                    flush,
    output DecodeTypes::PcT         recoveredPc
);

    // Pipeline register and drain state
    DecodeTypes::DecodeBundle pipeReg;
    logic                     occupied;
    logic                     initiate;
    DecodeTypes::MopMaskT     remaining;

    // Flattened view of the registered micro-ops
    DecodeTypes::MicroOp [DecodeTypes::AllMicroOpWidth-1:0] mops;

    DecodeTypes::MopMaskT freshMask;
    DecodeTypes::MopMaskT keepMask;
    DecodeTypes::MopMaskT pickReq;
    DecodeTypes::MopMaskT serMask;
    DecodeTypes::MopMaskT nextMask;

    logic [DecodeTypes::DecodeWidth-1:0]                   picked;
    DecodeTypes::MopIndexT [DecodeTypes::DecodeWidth-1:0]  pickedIndex;
    DecodeTypes::LaneIndexT [DecodeTypes::DecodeWidth-1:0] srcLane;

    logic [DecodeTypes::DecodeWidth-1:0] insnValidOut;
    logic                                flushReq;
    logic                                complete;
    logic                                accept;

    // Slot index to the instruction lane it belongs to
    function automatic DecodeTypes::LaneIndexT ToInsnLane(DecodeTypes::MopIndexT idx);
        return DecodeTypes::LaneIndexT'(idx / DecodeTypes::MicroOpMaxNum);
    endfunction

    DecodedBranchResolver u_resolver (
        .bundle      (pipeReg),
        .enable      (ctrl.resolverEnable),
        .insnValidOut(insnValidOut),
        .flushReq    (flushReq),
        .recoveredPc (recoveredPc)
    );

    always_comb begin
        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            for (int j = 0; j < DecodeTypes::MicroOpMaxNum; j++) begin
                mops[i*DecodeTypes::MicroOpMaxNum + j]      = pipeReg[i].microOps[j];
                freshMask[i*DecodeTypes::MicroOpMaxNum + j] =
                    pipeReg[i].valid && pipeReg[i].microOps[j].valid;
                // Dropped lanes never reach the picker
                keepMask[i*DecodeTypes::MicroOpMaxNum + j]  = insnValidOut[i];
            end
        end

        for (int k = 0; k < DecodeTypes::AllMicroOpWidth; k++) begin
            serMask[k] = mops[k].serialized || ctrl.serializeAll;
        end

        if (!occupied) begin
            pickReq = '0;
        end else if (initiate) begin
            pickReq = freshMask & keepMask;
        end else begin
            pickReq = remaining & keepMask;
        end
    end

    MicroOpPicker u_picker (
        .req        (pickReq),
        .serialize  (serMask),
        .picked     (picked),
        .pickedIndex(pickedIndex),
        .next       (nextMask)
    );

    always_comb begin
        complete = 1'b1;
        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            for (int j = 0; j < DecodeTypes::MicroOpMaxNum; j++) begin
                if (nextMask[i*DecodeTypes::MicroOpMaxNum + j] && insnValidOut[i]) begin
                    complete = 1'b0;
                end
            end
        end
    end

    // Empty stage counts as complete, so inReady follows the stall alone
    assign inReady = !outStall && (!occupied || complete);
    assign accept  = inValid && inReady;
    assign flush   = flushReq && complete && occupied && !outStall;

    always_comb begin
        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            srcLane[i]            = ToInsnLane(pickedIndex[i]);
            outLanes[i].valid     = occupied && picked[i] && insnValidOut[srcLane[i]];
            outLanes[i].pc        = pipeReg[srcLane[i]].pc;
            outLanes[i].predTaken = pipeReg[srcLane[i]].predTaken;
            outLanes[i].op        = mops[pickedIndex[i]];
        end
    end

    // Bundle payload
    always_ff @(posedge clk) begin
        if (accept) begin
            pipeReg <= inBundle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            occupied  <= 1'b0;
            initiate  <= 1'b1;
            remaining <= '0;
        end else if (!outStall) begin
            if (accept) begin
                occupied <= 1'b1;
            end else if (complete) begin
                occupied <= 1'b0;
            end
            // Fresh valid bits again once the bundle is done
            initiate  <= complete;
            remaining <= nextMask;
        end
    end

endmodule

/* hdl/DecodeConfigRegs.sv */
// Wishbone classic register block for the decode stage.
// Single-cycle ack after stb, no wait states, no error or retry.
// Word 0 holds the control bits, word 1 the saturating redirect count;
// writing word 1 clears the count, other words read zero.

`timescale 1ns/1ps

module DecodeConfigRegs (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  DecodeTypes::WbAddrT    adr,
    input  DecodeTypes::WbDataT    datW,
    output DecodeTypes::WbDataT    datR,
    output logic                   ack,
    output DecodeTypes::DecodeCtrl ctrl,
    input  logic                   flushPulse,
    input  logic                   flushAccepted
);

    DecodeTypes::WbDataT flushCount;
    DecodeTypes::WbDataT readValue;
    logic                request;

    // A new request only while no ack is outstanding
    assign request = cyc && stb && !ack;

    always_comb begin
        readValue = '0;
        case (adr)
            DecodeTypes::RegCtrlAddr: begin
                readValue[DecodeTypes::CtrlResolverBit]  = ctrl.resolverEnable;
                readValue[DecodeTypes::CtrlSerializeBit] = ctrl.serializeAll;
            end
            DecodeTypes::RegFlushCountAddr: begin
                readValue = flushCount;
            end
            default: begin
                readValue = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack        <= 1'b0;
            ctrl       <= DecodeTypes::CtrlReset;
            flushCount <= '0;
        end else begin
            ack <= request;

            if (flushPulse && flushAccepted && flushCount != DecodeTypes::FlushCountMax) begin
                flushCount <= flushCount + 1'b1;
            end

            // Clear beats a redirect in the same cycle
            if (request && we) begin
                if (adr == DecodeTypes::RegCtrlAddr) begin
                    ctrl.resolverEnable <= datW[DecodeTypes::CtrlResolverBit];
                    ctrl.serializeAll   <= datW[DecodeTypes::CtrlSerializeBit];
                end else if (adr == DecodeTypes::RegFlushCountAddr) begin
                    flushCount <= '0;
                end
            end
        end
    end

    // Read data, valid in the ack cycle
    always_ff @(posedge clk) begin
        if (request) begin
            datR <= readValue;
        end
    end

endmodule

/* hdl/DecodeSubsystem.sv */
// Top level: decode stage plus its Wishbone register block.
// A redirect is counted only in a cycle where rename is not stalled.

`timescale 1ns/1ps

module DecodeSubsystem (
    input  logic                     clk,
    input  logic                     rstN,
    // Front end
    input  DecodeTypes::DecodeBundle inBundle,
    input  logic                     inValid,
    output logic                     inReady,
    // Rename
    output DecodeTypes::IssueLanes   outLanes,
    input  logic                     outStall,
    // Fetch redirect
    output logic                     flush,
    output DecodeTypes::PcT          recoveredPc,
    // Register port
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  DecodeTypes::WbAddrT      adr,
    input  DecodeTypes::WbDataT      datW,
    output DecodeTypes::WbDataT      datR,
    output logic                     ack
);

    DecodeTypes::DecodeCtrl ctrl;

    DecodeStage u_DecodeStage (
        .clk        (clk),
        .rstN       (rstN),
        .inBundle   (inBundle),
        .inValid    (inValid),
        .inReady    (inReady),
        .outStall   (outStall),
        .ctrl       (ctrl),
        .outLanes   (outLanes),
        .flush      (flush),
        .recoveredPc(recoveredPc)
    );

    DecodeConfigRegs u_DecodeConfigRegs (
        .clk          (clk),
        .rstN         (rstN),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .datW         (datW),
        .datR         (datR),
        .ack          (ack),
        .ctrl         (ctrl),
        .flushPulse   (flush),
        .flushAccepted(!outStall)
    );

endmodule

/* testbench/DecodeSubsystem_sva.sv */
// Protocol checks bound into the decode subsystem top level.
// Lane stability under stall holds only while the control bits stay unchanged.
// The violations count is read by the testbench.

`timescale 1ns/1ps

module DecodeSubsystemSva (
    input logic                   clk,
    input logic                   rstN,
    input logic                   inReady,
    input logic                   outStall,
    input DecodeTypes::IssueLanes outLanes,
    input logic                   flush,
    input logic                   ack
);

    // Failures seen so far
    int violations = 0;

    // A stalled cycle leaves the lanes untouched
    laneHold: assert property (@(posedge clk) disable iff (!rstN)
        outStall |=> (outLanes === $past(outLanes)))
    else begin
        $error("outLanes changed in the cycle after outStall was high");
        violations++;
    end

    // Single-cycle ack
    ackPulse: assert property (@(posedge clk) disable iff (!rstN)
        ack |=> !ack)
    else begin
        $error("ack stayed high for more than one cycle");
        violations++;
    end

    // Redirect only in a completing cycle
    flushReady: assert property (@(posedge clk) disable iff (!rstN)
        flush |-> inReady)
    else begin
        $error("flush was high while inReady was low");
        violations++;
    end

endmodule

bind DecodeSubsystem DecodeSubsystemSva u_DecodeSubsystemSva (
    .clk     (clk),
    .rstN    (rstN),
    .inReady (inReady),
    .outStall(outStall),
    .outLanes(outLanes),
    .flush   (flush),
    .ack     (ack)
);

/* testbench/DecodeSubsystemTb.sv */
// Random bundles with random back-pressure against an in-order reference model.
// Control bits are rewritten only while the stage is drained and unstalled.

`timescale 1ns/1ps

module DecodeSubsystemTb;

    logic                     clk = 1'b0;
    logic                     rstN;
    DecodeTypes::DecodeBundle inBundle;
    logic                     inValid;
    logic                     inReady;
    DecodeTypes::IssueLanes   outLanes;
    logic                     outStall;
    logic                     flush;
    DecodeTypes::PcT          recoveredPc;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    DecodeTypes::WbAddrT      adr;
    DecodeTypes::WbDataT      datW;
    DecodeTypes::WbDataT      datR;
    logic                     ack;

    integer              seed = 32'h3406_29f5;
    int                  phaseBundles = 50;
    DecodeTypes::WbDataT readData;

    // Model queues hold one entry per accepted bundle except expOps
    DecodeTypes::IssuedOp expOps[$];
    int                   opsLeft[$];
    logic                 flushExp[$];
    DecodeTypes::PcT      targetExp[$];
    int unsigned          flushCount = 0;
    logic                 modelResolver = 1'b1;
    logic                 modelSerialize = 1'b0;

    DecodeSubsystem u_DecodeSubsystem (.*);

    always #20 clk = ~clk;

    task automatic failRun(input string detail);
        $display("%s", detail);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic DecodeTypes::DecodeBundle randomBundle();
        DecodeTypes::DecodeBundle b;
        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            b[i].valid      = ($random(seed) & 3) != 0;
            b[i].pc         = DecodeTypes::PcT'($random(seed)) & 32'hffff_fffc;
            b[i].isJump     = ($random(seed) & 3) == 0;
            b[i].predTaken  = 1'($random(seed));
            b[i].jumpTarget = DecodeTypes::PcT'($random(seed)) & 32'hffff_fffc;
            for (int j = 0; j < DecodeTypes::MicroOpMaxNum; j++) begin
                b[i].microOps[j].valid      = ($random(seed) & 3) != 0;
                b[i].microOps[j].serialized = ($random(seed) & 3) == 0;
                b[i].microOps[j].mid        = 1'(j);
                b[i].microOps[j].opCode     = 8'($random(seed));
            end
        end
        return b;
    endfunction

    // Expected micro-op order and redirect of one bundle
    task automatic predictBundle(input DecodeTypes::DecodeBundle b);
        DecodeTypes::IssuedOp op;
        DecodeTypes::PcT      target;
        logic                 cut;
        int                   count;
        cut    = 1'b0;
        count  = 0;
        target = '0;
        for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
            if (b[i].valid && !cut) begin
                for (int j = 0; j < DecodeTypes::MicroOpMaxNum; j++) begin
                    if (b[i].microOps[j].valid) begin
                        op.valid     = 1'b1;
                        op.pc        = b[i].pc;
                        op.predTaken = b[i].predTaken;
                        op.op        = b[i].microOps[j];
                        expOps.push_back(op);
                        count++;
                    end
                end
                // Jump still issues, later instructions do not
                if (modelResolver && b[i].isJump && !b[i].predTaken) begin
                    cut    = 1'b1;
                    target = b[i].jumpTarget;
                end
            end
        end
        opsLeft.push_back(count);
        flushExp.push_back(cut);
        targetExp.push_back(target);
    endtask

    always @(posedge clk) begin
        DecodeTypes::IssuedOp want;
        if (rstN) begin
            assert (!(outStall && inReady))
                else failRun($sformatf("ERROR inReady 0x%h while outStall 0x%h",
                                       inReady, outStall));
            if (!outStall) begin
                assert (!outLanes[1].valid || (outLanes[0].valid && !modelSerialize &&
                        !outLanes[0].op.serialized && !outLanes[1].op.serialized))
                    else failRun($sformatf("ERROR outLanes[1].valid 0x1 beside lane 0 0x%h",
                                           outLanes[0]));
                for (int i = 0; i < DecodeTypes::DecodeWidth; i++) begin
                    if (outLanes[i].valid) begin
                        assert (expOps.size() > 0)
                            else failRun("A micro-op was delivered that the model did not expect");
                        want = expOps.pop_front();
                        assert (outLanes[i] == want)
                            else failRun($sformatf("ERROR outLanes[%0d] 0x%h expected 0x%h",
                                                   i, outLanes[i], want));
                        opsLeft[0] = opsLeft[0] - 1;
                    end
                end
            end
            // Head bundle completes when intake reopens
            if (!outStall && inReady && opsLeft.size() > 0) begin
                assert (opsLeft[0] == 0)
                    else failRun($sformatf("A bundle completed with %0d micro-ops undelivered",
                                           opsLeft[0]));
                assert (flush == flushExp[0])
                    else failRun($sformatf("ERROR flush 0x%h expected 0x%h", flush, flushExp[0]));
                assert (!flush || recoveredPc == targetExp[0])
                    else failRun($sformatf("ERROR recoveredPc 0x%h expected 0x%h",
                                           recoveredPc, targetExp[0]));
                if (flushExp[0]) flushCount++;
                opsLeft.delete(0);
                flushExp.delete(0);
                targetExp.delete(0);
            end else begin
                assert (!flush) else failRun("flush was raised while no bundle was completing");
            end
            if (inValid && inReady) predictBundle(inBundle);
        end
    end

    always @(negedge clk) begin
        assert (u_DecodeSubsystem.u_DecodeSubsystemSva.violations == 0)
            else failRun("A bound protocol assertion failed");
    end

    task automatic accessRegister(input logic write, input DecodeTypes::WbAddrT a,
                                  input DecodeTypes::WbDataT d);
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = write;
        adr  = a;
        datW = d;
        do @(posedge clk); while (!ack);
        readData = datR;
        @(negedge clk);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic expectRegister(input DecodeTypes::WbAddrT a, input DecodeTypes::WbDataT want);
        accessRegister(1'b0, a, '0);
        assert (readData == want)
            else failRun($sformatf("ERROR datR 0x%h expected 0x%h at adr 0x%h", readData, want, a));
    endtask

    task automatic sendBundles(input int count);
        int   sent;
        logic took;
        sent = 0;
        took = 1'b1;
        while (sent < count) begin
            @(negedge clk);
            outStall = ($random(seed) & 3) == 0;
            if (took || !inValid) begin
                inValid = ($random(seed) & 7) != 0;
                inBundle = randomBundle();
            end
            @(posedge clk);
            took = inValid && inReady;
            if (took) sent++;
        end
        @(negedge clk);
        inValid  = 1'b0;
        outStall = 1'b0;
    endtask

    task automatic runPhase(input logic resolverOn, input logic serializeOn);
        DecodeTypes::WbDataT word;
        word = '0;
        word[DecodeTypes::CtrlResolverBit]  = resolverOn;
        word[DecodeTypes::CtrlSerializeBit] = serializeOn;
        accessRegister(1'b1, DecodeTypes::RegCtrlAddr, word);
        modelResolver  = resolverOn;
        modelSerialize = serializeOn;
        expectRegister(DecodeTypes::RegCtrlAddr, word);
        sendBundles(phaseBundles);
        while (opsLeft.size() != 0) @(negedge clk);
        expectRegister(DecodeTypes::RegFlushCountAddr, flushCount);
    endtask

    // Watchdog sized from the bundle count of all phases
    initial begin
        repeat (4 * phaseBundles * 20 + 400) @(posedge clk);
        failRun("Timeout, the simulation hung waiting for the DUT");
    end

    initial begin
        rstN     = 1'b0;
        inBundle = '0;
        inValid  = 1'b0;
        outStall = 1'b0;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        datW     = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(posedge clk);
        assert (inReady && !flush && !ack && !outLanes[0].valid && !outLanes[1].valid)
            else failRun($sformatf("ERROR after reset inReady 0x%h flush 0x%h ack 0x%h",
                                   inReady, flush, ack));
        expectRegister(DecodeTypes::RegCtrlAddr, 32'h1);
        expectRegister(DecodeTypes::RegFlushCountAddr, 32'h0);

        // Default phase then all serialized then resolver off
        runPhase(1'b1, 1'b0);
        runPhase(1'b1, 1'b1);
        runPhase(1'b0, 1'b0);

        // Counter clear then redirects counted again from zero
        accessRegister(1'b1, DecodeTypes::RegFlushCountAddr, '1);
        flushCount = 0;
        expectRegister(DecodeTypes::RegFlushCountAddr, 32'h0);
        runPhase(1'b1, 1'b0);

        // Unmapped word reads zero and ignores writes
        accessRegister(1'b1, 4'h7, '1);
        expectRegister(4'h7, 32'h0);
        expectRegister(DecodeTypes::RegCtrlAddr, 32'h1);

        if (u_DecodeSubsystem.u_DecodeSubsystemSva.violations == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            failRun("A bound protocol assertion failed");
        end
    end

endmodule

/* flist.f */
hdl/DecodeTypes.sv
hdl/MicroOpPicker.sv
hdl/DecodedBranchResolver.sv
hdl/DecodeStage.sv
hdl/DecodeConfigRegs.sv
hdl/DecodeSubsystem.sv
testbench/DecodeSubsystem_sva.sv
testbench/DecodeSubsystemTb.sv
